/* compile.f */
rtl/st_glue_pkg.sv
rtl/ram_phase_arbiter.sv
rtl/cpu_mem_map.sv
rtl/io_decode.sv
rtl/bus_cycle_ctrl.sv
rtl/irq_controller.sv
rtl/st_glue_top.sv
test/st_glue_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the ST glue testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module st_glue_tb -o st_glue_sim
./obj_dir/st_glue_sim | tee sim.log
if grep -q "Test failed" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
	echo "simulation ended early, see sim.log"
	exit 1
fi
echo "simulation passed"

/* test/st_glue_tb.sv */
////////////////////////////////////////////////////////////
// directed testbench for the ST bus glue, clk_8 period 40
// br parks high between accesses so the timeout stays clear
////////////////////////////////////////////////////////////

module st_glue_tb;

	localparam int CLK_PERIOD   = 40;
	localparam int BERR_TIMEOUT = 31;
	localparam int N_SIZES      = 6;
	localparam int N_REGIONS    = 9;
	// summed test lengths in cycles, plus margin
	localparam int WATCH_CYCLES = 20 + N_SIZES * N_REGIONS * 2 * 6 + 7 * 8 + 2 * 24 +
		2 * (BERR_TIMEOUT + 10) + 200;

	logic                           clk_8;
	logic                           pll_locked;
	logic [st_glue_pkg::ADDR_W-1:0] cpu_addr;
	logic                           cpu_rw;
	logic                           cpu_uds_n;
	logic                           cpu_lds_n;
	logic                           br;
	st_glue_pkg::mem_size_t         mem_size;
	logic [st_glue_pkg::DATA_W-1:0] cpu_din;
	logic                           dtack_n;
	logic                           berr;
	logic [3:0]                     berr_count;
	logic [2:0]                     ipl;
	logic                           vs, hs, mfp_irq;
	logic [st_glue_pkg::ADDR_W-1:0] video_addr;
	logic                           video_read;
	logic [st_glue_pkg::DATA_W-1:0] ram_rdata;
	st_glue_pkg::bus_phase_t        bus_phase;
	logic [st_glue_pkg::ADDR_W-1:0] ram_addr;
	logic                           ram_oe_n, ram_we_n, ram_uds_n, ram_lds_n;
	logic [st_glue_pkg::DATA_W-1:0] vreg_rdata, dma_rdata;
	logic [7:0]                     mmu_rdata, mfp_rdata, acia_rdata, psg_rdata;
	logic                           vreg_sel, mmu_sel, mfp_sel, acia_sel, psg_sel, dma_sel;
	logic                           mfp_iack;

	logic [31:0] lfsr;	// stimulus source
	string       test_name;
	int          errors;
	int          test_errors;
	int          tests_run;

	st_glue_top #(.BERR_TIMEOUT(BERR_TIMEOUT)) st_glue_top_i (.*);

	always #(CLK_PERIOD / 2) clk_8 = ~clk_8;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);	// one step per bit
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// st ram present for this byte address and size code
	function automatic logic ram_expected(logic [23:0] a, int size);
		if (a < 24'h400000)
			return 1'b1;
		if (a < 24'h800000)
			return size >= 4;	// 8M and 14M
		if (a < 24'he00000)
			return size == 5;
		return 1'b0;
	endfunction

	function automatic logic mem_expected(logic [23:0] a, int size, logic rd);
		logic rom;
		// tos low, then cart and tos high back to back
		rom = (a >= 24'he00000 && a <= 24'he3ffff) || (a >= 24'hfa0000 && a <= 24'hfeffff);
		return ram_expected(a, size) || (rd && rom);
	endfunction

	task automatic tick();
		@(posedge clk_8);
		#5;	// drive point
	endtask

	task automatic begin_test(string name);
		test_name = name;
		test_errors = 0;
		tests_run++;
	endtask

	task automatic end_test();
		$display("test %s finished with %0d errors", test_name, test_errors);
	endtask

	task automatic report(string what, logic [31:0] exp, logic [31:0] act);
		$display("error %s %s: expected %0h, actual %0h", test_name, what, exp, act);
		errors++;
		test_errors++;
	endtask

	task automatic complain(string msg);
		$display("%s: %s", test_name, msg);
		errors++;
		test_errors++;
	endtask

	// strobed access, returns settled inside the cpu slot
	task automatic cpu_access(logic [22:0] addr, logic rd);
		tick();
		cpu_addr  = addr;
		cpu_rw    = rd;
		cpu_uds_n = 1'b0;
		cpu_lds_n = 1'b0;
		br        = 1'b0;
		for (int i = 0; i < 4 && bus_phase != st_glue_pkg::PHASE_CPU; i++)
			tick();
		if (bus_phase != st_glue_pkg::PHASE_CPU)
			complain("bus_phase never reached the cpu slot");
		#20;	// sample mid cycle
	endtask

	task automatic bus_idle();
		tick();
		cpu_uds_n = 1'b1;
		cpu_lds_n = 1'b1;
		cpu_rw    = 1'b1;
		br        = 1'b1;	// holds the timeout at zero
	endtask

	task automatic phase_ram_test();
		logic [22:0] addr;
		int          exp_phase;
		begin_test("phase_ram");
		if (bus_phase !== st_glue_pkg::PHASE_VIDEO)
			report("reset bus_phase", 0, bus_phase);
		if ({dtack_n, berr, berr_count} !== 6'b100000)
			report("reset dtack_n berr berr_count", 6'b100000, {dtack_n, berr, berr_count});
		if (ipl !== 3'b111)
			report("reset ipl", 3'b111, ipl);
		if ({vreg_sel, mmu_sel, mfp_sel, acia_sel, psg_sel, dma_sel, mfp_iack} !== 7'b0)
			report("reset selects", 0, {vreg_sel, mmu_sel, mfp_sel, acia_sel, psg_sel,
				dma_sel, mfp_iack});
		if ({ram_we_n, ram_oe_n} !== 2'b11)
			report("reset ram_we_n ram_oe_n", 2'b11, {ram_we_n, ram_oe_n});
		exp_phase = 0;
		for (int i = 0; i < 8; i++) begin
			tick();
			video_addr = 23'(take_bits(23));
			video_read = take_bits(1) != 0;
			exp_phase = (exp_phase + 1) % 4;	// video, host, cpu, spare
			#20;
			if (int'(bus_phase) != exp_phase)
				report("bus_phase", exp_phase, bus_phase);
			if (exp_phase == 0 && ram_addr !== video_addr)
				report("ram_addr in video slot", video_addr, ram_addr);
			if (exp_phase == 0 && ram_oe_n !== !video_read)
				report("ram_oe_n in video slot", !video_read, ram_oe_n);
			// shifter takes both lanes, cpu strobes are idle here
			if (exp_phase == 0 && {ram_uds_n, ram_lds_n} !== 2'b00)
				report("ram byte lanes in video slot", 2'b00, {ram_uds_n, ram_lds_n});
			if (exp_phase != 0 && {ram_uds_n, ram_lds_n} !== 2'b11)
				report("ram byte lanes outside video slot", 2'b11,
					{ram_uds_n, ram_lds_n});
		end
		addr = 23'(take_bits(21));	// first 4 MB
		ram_rdata = 16'(take_bits(16));
		cpu_access(addr, 1'b1);
		if ({ram_oe_n, ram_we_n} !== 2'b01)
			report("ram_oe_n ram_we_n on cpu read", 2'b01, {ram_oe_n, ram_we_n});
		if (ram_addr !== addr)
			report("ram_addr in cpu slot", addr, ram_addr);
		if (cpu_din !== ram_rdata)
			report("cpu_din on ram read", ram_rdata, cpu_din);
		bus_idle();
		end_test();
	endtask

	task automatic mem_map_test();
		logic [23:0] base [N_REGIONS];
		int          span [N_REGIONS];
		logic [23:0] byte_addr;
		logic        exp_ram;
		logic        exp_mem;
		base = '{24'h000000, 24'h400000, 24'h800000, 24'hc00000, 24'he00000,
			24'hf00000, 24'hfa0000, 24'hfc0000, 24'hfe0000};
		span = '{22, 22, 22, 21, 18, 19, 17, 17, 16};	// log2 of region bytes
		begin_test("mem_map");
		for (int s = 0; s < N_SIZES; s++) begin
			mem_size = st_glue_pkg::mem_size_t'(s);
			for (int r = 0; r < N_REGIONS; r++) begin
				for (int w = 0; w < 2; w++) begin
					byte_addr = base[r] | 24'(take_bits(span[r] - 1) << 1);
					exp_ram = ram_expected(byte_addr, s);
					exp_mem = mem_expected(byte_addr, s, w == 0);
					cpu_access(byte_addr[23:1], w == 0);	// read first, then write
					if (w == 0 && ram_oe_n !== !exp_mem)
						report($sformatf("ram_oe_n at %h size %0d", byte_addr, s),
							!exp_mem, ram_oe_n);
					if (w == 1 && ram_we_n !== !exp_ram)
						report($sformatf("ram_we_n at %h size %0d", byte_addr, s),
							!exp_ram, ram_we_n);
					if (dtack_n !== !exp_mem)
						report($sformatf("dtack_n at %h size %0d", byte_addr, s),
							!exp_mem, dtack_n);
					bus_idle();
				end
			end
		end
		mem_size = st_glue_pkg::MEM_4M;
		end_test();
	endtask

	task automatic io_decode_test();
		logic [15:0] base [6];
		int          span [6];
		logic [15:0] off;
		logic [15:0] exp_din;
		logic [5:0]  exp_sel;
		logic [5:0]  sel;
		// same order as the select vector, vreg down to dma
		base = '{16'h8200, 16'h8000, 16'hfa00, 16'hfc00, 16'h8800, 16'h8600};
		span = '{7, 1, 8, 8, 8, 4};
		begin_test("io_decode");
		for (int k = 0; k < 6; k++) begin
			off = base[k] | 16'(take_bits(span[k] - 1) << 1);
			vreg_rdata = 16'(take_bits(16));
			dma_rdata  = 16'(take_bits(16));
			mmu_rdata  = 8'(take_bits(8));
			mfp_rdata  = 8'(take_bits(8));
			acia_rdata = 8'(take_bits(8));
			psg_rdata  = 8'(take_bits(8));
			case (k)
				0: exp_din = vreg_rdata;
				1: exp_din = {8'h00, mmu_rdata};
				2: exp_din = {8'h00, mfp_rdata};
				3: exp_din = {acia_rdata, 8'h00};	// upper lane
				4: exp_din = {psg_rdata, 8'h00};
				default: exp_din = dma_rdata;
			endcase
			exp_sel = 6'b100000 >> k;
			cpu_access({8'hff, off[15:1]}, 1'b1);
			for (int p = 0; p < 4; p++) begin
				if (p > 0) begin
					tick();
					#20;
				end
				sel = {vreg_sel, mmu_sel, mfp_sel, acia_sel, psg_sel, dma_sel};
				if (bus_phase == st_glue_pkg::PHASE_CPU) begin
					if (sel !== exp_sel)
						report($sformatf("selects at ff%h", off), exp_sel, sel);
					if (cpu_din !== exp_din)
						report($sformatf("cpu_din at ff%h", off), exp_din, cpu_din);
				end else if (sel !== 6'b0) begin
					report($sformatf("selects outside cpu slot at ff%h", off), 0, sel);
				end
			end
			bus_idle();
		end
		// level 6 acknowledge, mfp puts its own vector on the low byte
		mfp_rdata = 8'(take_bits(8));
		cpu_access(23'h7ffffe, 1'b1);
		if (mfp_iack !== 1'b1)
			report("mfp_iack on level 6 acknowledge", 1, mfp_iack);
		if (cpu_din !== {8'h00, mfp_rdata})
			report("cpu_din on level 6 acknowledge", {8'h00, mfp_rdata}, cpu_din);
		bus_idle();
		ram_rdata = 16'(take_bits(16));
		cpu_access(23'(take_bits(21)), 1'b1);
		if (cpu_din !== ram_rdata)
			report("cpu_din on ram read", ram_rdata, cpu_din);
		bus_idle();
		end_test();
	endtask

	task automatic irq_round(logic use_vs);
		logic [2:0]  exp_ipl;
		logic [15:0] exp_vec;
		logic [22:0] ack_addr;
		logic        seen;
		exp_ipl  = use_vs ? 3'b011 : 3'b101;
		exp_vec  = use_vs ? 16'h001c : 16'h001a;
		ack_addr = use_vs ? 23'h7ffffc : 23'h7ffffa;	// level on A3..A1
		mfp_rdata = 8'(take_bits(8));	// must stay off the autovector
		tick();
		vs = use_vs;
		hs = !use_vs;
		seen = 1'b0;
		for (int i = 0; i < 8 && !seen; i++) begin
			tick();
			#20;
			seen = (ipl === exp_ipl);
		end
		if (!seen)
			complain("ipl did not reach the video level within 8 cycles");
		tick();
		vs = 1'b0;
		hs = 1'b0;
		mfp_irq = 1'b1;
		tick();
		#20;
		if (ipl !== 3'b001)
			report("ipl with mfp_irq", 3'b001, ipl);
		tick();
		mfp_irq = 1'b0;
		tick();
		#20;
		if (ipl !== exp_ipl)
			report("ipl after mfp_irq drops", exp_ipl, ipl);
		cpu_access(ack_addr, 1'b1);
		if (cpu_din !== exp_vec)
			report("autovector", exp_vec, cpu_din);
		if (dtack_n !== 1'b0)
			report("dtack_n on acknowledge", 0, dtack_n);
		bus_idle();	// pending flag clears on this edge
		tick();
		#20;
		if (ipl !== 3'b111)
			report("ipl after acknowledge", 3'b111, ipl);
	endtask

	task automatic irq_test();
		begin_test("irq");
		irq_round(1'b1);	// vbi
		irq_round(1'b0);	// hbi
		end_test();
	endtask

	task automatic bus_error_test();
		logic [3:0] exp_count;
		begin_test("bus_error");
		if (berr_count !== 4'd0)
			report("berr_count before timeout", 0, berr_count);
		exp_count = 4'd1;	// first timeout since reset
		tick();
		cpu_addr  = 23'h7fc500;	// $ff8a00, no window
		cpu_rw    = 1'b1;
		cpu_uds_n = 1'b0;
		cpu_lds_n = 1'b0;
		br        = 1'b0;
		for (int i = 0; i < BERR_TIMEOUT + 8; i++) begin
			tick();
			#20;
			if (dtack_n !== 1'b1)
				report("dtack_n on unmapped access", 1, dtack_n);
		end
		if (berr !== 1'b1)
			report("berr after timeout", 1, berr);
		if (berr_count !== exp_count)
			report("berr_count", exp_count, berr_count);
		bus_idle();
		tick();
		#20;
		if (berr !== 1'b0)
			report("berr after br rises", 0, berr);
		tick();
		cpu_addr  = 23'(take_bits(21));	// ram read held off by br
		cpu_uds_n = 1'b0;
		cpu_lds_n = 1'b0;
		for (int i = 0; i < BERR_TIMEOUT + 8; i++) begin
			tick();
			#20;
			if ({dtack_n, berr} !== 2'b10)
				report("dtack_n berr with br high", 2'b10, {dtack_n, berr});
		end
		bus_idle();
		end_test();
	endtask

	initial begin
		#(WATCH_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCH_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		clk_8 = 1'b0;
		pll_locked = 1'b0;
		cpu_addr = '0;
		cpu_rw = 1'b1;
		cpu_uds_n = 1'b1;
		cpu_lds_n = 1'b1;
		br = 1'b1;
		mem_size = st_glue_pkg::MEM_4M;
		vs = 1'b0;
		hs = 1'b0;
		mfp_irq = 1'b0;
		video_addr = '0;
		video_read = 1'b0;
		ram_rdata = '0;
		vreg_rdata = '0;
		dma_rdata = '0;
		mmu_rdata = '0;
		mfp_rdata = '0;
		acia_rdata = '0;
		psg_rdata = '0;
		lfsr = 32'hfd8ed460;
		errors = 0;
		tests_run = 0;
		repeat (4) @(posedge clk_8);
		#5;
		pll_locked = 1'b1;
		#20;	// still in the video slot here
		phase_ram_test();
		mem_map_test();
		io_decode_test();
		irq_test();
		bus_error_test();
		$display("summary: %0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* rtl/st_glue_top.sv */
////////////////////////////////////////////////////////////
// ST bus glue top, everything on clk_8
// peripherals and ram are external, their data come in as ports
////////////////////////////////////////////////////////////

module st_glue_top #(
	parameter int BERR_TIMEOUT = 31
) (
	input  logic                           clk_8,
	input  logic                           pll_locked,
	// cpu bus
	input  logic [st_glue_pkg::ADDR_W-1:0] cpu_addr,
	input  logic                           cpu_rw,
	input  logic                           cpu_uds_n,
	input  logic                           cpu_lds_n,
	input  logic                           br,	// dma bus request
	input  st_glue_pkg::mem_size_t         mem_size,
	output logic [st_glue_pkg::DATA_W-1:0] cpu_din,
	output logic                           dtack_n,
	output logic                           berr,
	output logic [3:0]                     berr_count,
	output logic [2:0]                     ipl,
	// video and interrupts
	input  logic                           vs,
	input  logic                           hs,
	input  logic                           mfp_irq,
	input  logic [st_glue_pkg::ADDR_W-1:0] video_addr,
	input  logic                           video_read,
	// st ram port
	input  logic [st_glue_pkg::DATA_W-1:0] ram_rdata,
	output st_glue_pkg::bus_phase_t        bus_phase,
	output logic [st_glue_pkg::ADDR_W-1:0] ram_addr,
	output logic                           ram_oe_n,
	output logic                           ram_we_n,
	output logic                           ram_uds_n,
	output logic                           ram_lds_n,
	// peripherals
	input  logic [st_glue_pkg::DATA_W-1:0] vreg_rdata,
	input  logic [st_glue_pkg::DATA_W-1:0] dma_rdata,
	input  logic [7:0]                     mmu_rdata,
	input  logic [7:0]                     mfp_rdata,
	input  logic [7:0]                     acia_rdata,
	input  logic [7:0]                     psg_rdata,
	output logic                           vreg_sel,
	output logic                           mmu_sel,
	output logic                           mfp_sel,
	output logic                           acia_sel,
	output logic                           psg_sel,
	output logic                           dma_sel,
	output logic                           mfp_iack
);

	logic strobe;	// any data strobe
	logic to_ram, to_mem, to_io, to_iack;	// address class
	logic bus_ack;
	logic vbi_ack, hbi_ack;

	ram_phase_arbiter ram_phase_arbiter_i (
		.clk_8(clk_8), .pll_locked(pll_locked),
		.video_addr(video_addr), .video_read(video_read),
		.cpu_addr(cpu_addr), .cpu_rw(cpu_rw),
		.cpu_uds_n(cpu_uds_n), .cpu_lds_n(cpu_lds_n),
		.strobe(strobe), .to_mem(to_mem), .to_ram(to_ram),
		.bus_phase(bus_phase), .ram_addr(ram_addr),
		.ram_oe_n(ram_oe_n), .ram_we_n(ram_we_n),
		.ram_uds_n(ram_uds_n), .ram_lds_n(ram_lds_n)
	);

	cpu_mem_map cpu_mem_map_i (
		.cpu_addr(cpu_addr), .cpu_rw(cpu_rw),
		.cpu_uds_n(cpu_uds_n), .cpu_lds_n(cpu_lds_n), .mem_size(mem_size),
		.strobe(strobe), .to_ram(to_ram), .to_mem(to_mem),
		.to_io(to_io), .to_iack(to_iack)
	);

	io_decode io_decode_i (
		.cpu_addr(cpu_addr), .bus_phase(bus_phase), .strobe(strobe),
		.to_mem(to_mem), .to_io(to_io), .to_iack(to_iack),
		.ram_rdata(ram_rdata), .vreg_rdata(vreg_rdata), .dma_rdata(dma_rdata),
		.mmu_rdata(mmu_rdata), .mfp_rdata(mfp_rdata),
		.acia_rdata(acia_rdata), .psg_rdata(psg_rdata),
		.vreg_sel(vreg_sel), .mmu_sel(mmu_sel), .mfp_sel(mfp_sel),
		.acia_sel(acia_sel), .psg_sel(psg_sel), .dma_sel(dma_sel),
		.mfp_iack(mfp_iack), .vbi_ack(vbi_ack), .hbi_ack(hbi_ack),
		.bus_ack(bus_ack), .cpu_din(cpu_din)
	);

	bus_cycle_ctrl #(.BERR_TIMEOUT(BERR_TIMEOUT)) bus_cycle_ctrl_i (
		.clk_8(clk_8), .pll_locked(pll_locked),
		.bus_ack(bus_ack), .br(br),
		.dtack_n(dtack_n), .berr(berr), .berr_count(berr_count)
	);

	irq_controller irq_controller_i (
		.clk_8(clk_8), .pll_locked(pll_locked),
		.vs(vs), .hs(hs), .mfp_irq(mfp_irq),
		.vbi_ack(vbi_ack), .hbi_ack(hbi_ack), .ipl(ipl)
	);

endmodule

/* rtl/irq_controller.sv */
////////////////////////////////////////////////////////////
// vbi/hbi edge latches and ipl encoder, vs and hs async
// mfp level has top priority, then vbi, then hbi
////////////////////////////////////////////////////////////

module irq_controller (
	input  logic       clk_8,
	input  logic       pll_locked,
	input  logic       vs,
	input  logic       hs,
	input  logic       mfp_irq,
	input  logic       vbi_ack,
	input  logic       hbi_ack,
	output logic [2:0] ipl
);

	logic vs_meta, vs_sync, vs_prev;	// two flop sync plus edge history
	logic hs_meta, hs_sync, hs_prev;
	logic vs_rise;	// one clk_8 pulse
	logic hs_rise;
	logic vbi;	// level 4 pending
	logic hbi;	// level 2 pending

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			vs_meta <= 1'b0;
			vs_sync <= 1'b0;
			vs_prev <= 1'b0;
			hs_meta <= 1'b0;
			hs_sync <= 1'b0;
			hs_prev <= 1'b0;
		end else begin
			vs_meta <= vs;
			vs_sync <= vs_meta;
			vs_prev <= vs_sync;
			hs_meta <= hs;
			hs_sync <= hs_meta;
			hs_prev <= hs_sync;
		end
	end

	assign vs_rise = vs_sync && !vs_prev;
	assign hs_rise = hs_sync && !hs_prev;

	// pending flags, ack wins over a new edge
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			vbi <= 1'b0;
			hbi <= 1'b0;
		end else begin
			if (vbi_ack)
				vbi <= 1'b0;
			else if (vs_rise)
				vbi <= 1'b1;
			if (hbi_ack)
				hbi <= 1'b0;
			else if (hs_rise)
				hbi <= 1'b1;
		end
	end

	// registered priority encoder
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			ipl <= st_glue_pkg::IPL_NONE;
		end else if (mfp_irq) begin
			ipl <= st_glue_pkg::IPL_MFP;	// level 6
		end else if (vbi) begin
			ipl <= st_glue_pkg::IPL_VBI;	// level 4
		end else if (hbi) begin
			ipl <= st_glue_pkg::IPL_HBI;	// level 2
		end else begin
			ipl <= st_glue_pkg::IPL_NONE;
		end
	end

endmodule

/* rtl/bus_cycle_ctrl.sv */
////////////////////////////////////////////////////////////
// dtack and bus error timeout, br halts the cpu via dtack
// timeout also runs while the cpu is idle, br clears it
////////////////////////////////////////////////////////////

module bus_cycle_ctrl #(
	parameter int BERR_TIMEOUT = 31	// cycles without dtack before berr
) (
	input  logic       clk_8,
	input  logic       pll_locked,
	input  logic       bus_ack,
	input  logic       br,
	output logic       dtack_n,
	output logic       berr,
	output logic [3:0] berr_count
);

	localparam int CNT_W = $clog2(BERR_TIMEOUT + 1);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(BERR_TIMEOUT);

	logic [CNT_W-1:0] timeout_cnt;
	logic             berr_q;	// berr one cycle back, for rise detect

	assign dtack_n = !(bus_ack && !br);	// dma owns the bus while br high
	assign berr    = (timeout_cnt == CNT_MAX);

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			timeout_cnt <= '0;
			berr_q      <= 1'b0;
			berr_count  <= 4'd0;
		end else begin
			berr_q <= berr;
			if (!dtack_n || br)
				timeout_cnt <= '0;
			else if (timeout_cnt != CNT_MAX)
				timeout_cnt <= timeout_cnt + 1'b1;	// saturate at max
			if (berr && !berr_q)
				berr_count <= berr_count + 4'd1;	// debug trigger, wraps
		end
	end

	// a late ack on top of an expired timeout would give dtack and berr together
	a_no_berr_dtack: assert property (@(posedge clk_8) disable iff (!pll_locked)
		!dtack_n |-> !berr);

endmodule

/* rtl/io_decode.sv */
////////////////////////////////////////////////////////////
// peripheral selects and cpu read data merge
// unselected peripherals are masked before the OR merge
////////////////////////////////////////////////////////////

module io_decode (
	input  logic [st_glue_pkg::ADDR_W-1:0] cpu_addr,
	input  st_glue_pkg::bus_phase_t        bus_phase,
	input  logic                           strobe,
	input  logic                           to_mem,
	input  logic                           to_io,
	input  logic                           to_iack,
	input  logic [st_glue_pkg::DATA_W-1:0] ram_rdata,
	input  logic [st_glue_pkg::DATA_W-1:0] vreg_rdata,
	input  logic [st_glue_pkg::DATA_W-1:0] dma_rdata,
	input  logic [7:0]                     mmu_rdata,
	input  logic [7:0]                     mfp_rdata,
	input  logic [7:0]                     acia_rdata,
	input  logic [7:0]                     psg_rdata,
	output logic                           vreg_sel,
	output logic                           mmu_sel,
	output logic                           mfp_sel,
	output logic                           acia_sel,
	output logic                           psg_sel,
	output logic                           dma_sel,
	output logic                           mfp_iack,
	output logic                           vbi_ack,
	output logic                           hbi_ack,
	output logic                           bus_ack,
	output logic [st_glue_pkg::DATA_W-1:0] cpu_din
);

	logic        cpu_cycle;	// cpu owns this slot
	logic        io_cycle;
	logic        iack_cycle;
	logic [15:1] io_off;	// byte offset in the $ff page, A0 dropped
	logic [7:0]  auto_vec;
	logic [7:0]  din_hi;	// acia, psg
	logic [7:0]  din_lo;	// mmu, mfp, vectors
	logic [15:0] din_word;	// vreg, dma

	assign cpu_cycle  = (bus_phase == st_glue_pkg::PHASE_CPU);
	assign io_cycle   = cpu_cycle && strobe && to_io;
	assign iack_cycle = cpu_cycle && strobe && to_iack;
	assign io_off     = cpu_addr[14:0];

	// window compares, low bits ignored per window size
	assign mmu_sel  = io_cycle && (io_off[15:1] == st_glue_pkg::MMU_BASE[15:1]);
	assign vreg_sel = io_cycle && (io_off[15:7] == st_glue_pkg::VREG_BASE[15:7]);
	assign dma_sel  = io_cycle && (io_off[15:4] == st_glue_pkg::DMA_BASE[15:4]);
	assign psg_sel  = io_cycle && (io_off[15:8] == st_glue_pkg::PSG_BASE[15:8]);
	assign mfp_sel  = io_cycle && (io_off[15:8] == st_glue_pkg::MFP_BASE[15:8]);
	assign acia_sel = io_cycle && (io_off[15:8] == st_glue_pkg::ACIA_BASE[15:8]);

	// interrupt level sits on A3..A1
	assign mfp_iack = iack_cycle && (cpu_addr[2:0] == 3'b110);	// mfp gives its own vector
	assign vbi_ack  = iack_cycle && (cpu_addr[2:0] == 3'b100);
	assign hbi_ack  = iack_cycle && (cpu_addr[2:0] == 3'b010);

	assign auto_vec = ({8{vbi_ack}} & st_glue_pkg::VEC_VBI) |
		({8{hbi_ack}} & st_glue_pkg::VEC_HBI);

	// anything decoded ends the cycle, unmapped space times out
	assign bus_ack = vreg_sel || mmu_sel || mfp_sel || acia_sel || psg_sel || dma_sel ||
		mfp_iack || vbi_ack || hbi_ack || (cpu_cycle && strobe && to_mem);

	assign din_hi   = ({8{acia_sel}} & acia_rdata) | ({8{psg_sel}} & psg_rdata);
	assign din_lo   = ({8{mmu_sel}} & mmu_rdata) |
		({8{mfp_sel || mfp_iack}} & mfp_rdata) | auto_vec;
	assign din_word = ({16{vreg_sel}} & vreg_rdata) | ({16{dma_sel}} & dma_rdata);

	assign cpu_din = to_mem ? ram_rdata : (din_word | {din_hi, din_lo});

	// windows are disjoint, so two selects at once means a broken decode
	always_comb begin
		a_one_sel: assert final ($onehot0({vreg_sel, mmu_sel, mfp_sel,
			acia_sel, psg_sel, dma_sel}));
	end

endmodule

/* rtl/cpu_mem_map.sv */
////////////////////////////////////////////////////////////
// 68000 memory map, purely combinational
// rom and cartridge areas decode as memory for reads only
////////////////////////////////////////////////////////////

module cpu_mem_map (
	input  logic [st_glue_pkg::ADDR_W-1:0] cpu_addr,
	input  logic                           cpu_rw,
	input  logic                           cpu_uds_n,
	input  logic                           cpu_lds_n,
	input  st_glue_pkg::mem_size_t         mem_size,
	output logic                           strobe,
	output logic                           to_ram,
	output logic                           to_mem,
	output logic                           to_io,
	output logic                           to_iack
);

	localparam int MSB = st_glue_pkg::ADDR_W - 1;	// index of cpu A23

	logic ram_14m;	// $800000..$dfffff present
	logic ram_8m;	// $400000..$7fffff present
	logic tos_256k;	// $e00000..$e3ffff
	logic tos_192k;	// $fc0000..$feffff
	logic cart;	// $fa0000..$fbffff

	assign ram_14m = (mem_size == st_glue_pkg::MEM_14M);
	assign ram_8m  = (mem_size == st_glue_pkg::MEM_8M) || ram_14m;

	always_comb begin
		to_ram = (cpu_addr[MSB -: 2] == 2'b00);	// plain 4 MB, any size
		if (ram_8m && (cpu_addr[MSB -: 2] == 2'b01))
			to_ram = 1'b1;
		if (ram_14m && ((cpu_addr[MSB -: 2] == 2'b10) || (cpu_addr[MSB -: 3] == 3'b110)))
			to_ram = 1'b1;
	end

	assign tos_256k = (cpu_addr[MSB -: 6] == 6'b111000);
	assign tos_192k = (cpu_addr[MSB -: 7] == 7'b1111110) ||
		(cpu_addr[MSB -: 8] == 8'b11111110);
	assign cart     = (cpu_addr[MSB -: 7] == 7'b1111101);

	// ram read/write, rom and cart read only
	assign to_mem = to_ram || (cpu_rw && (tos_256k || tos_192k || cart));

	assign to_io   = (cpu_addr[MSB -: 8] == 8'hff);	// $ff0000 up
	assign to_iack = (cpu_addr[MSB -: 20] == 20'hfffff);	// $fffff0 up, level in A3..A1

	assign strobe = !cpu_uds_n || !cpu_lds_n;	// either byte lane

endmodule

/* rtl/ram_phase_arbiter.sv */
////////////////////////////////////////////////////////////
// ram port mux, video owns slot 0, cpu owns slot 2
// host and spare slots present the cpu bus but never strobe
////////////////////////////////////////////////////////////

module ram_phase_arbiter (
	input  logic                             clk_8,
	input  logic                             pll_locked,
	input  logic [st_glue_pkg::ADDR_W-1:0]   video_addr,
	input  logic                             video_read,
	input  logic [st_glue_pkg::ADDR_W-1:0]   cpu_addr,
	input  logic                             cpu_rw,
	input  logic                             cpu_uds_n,
	input  logic                             cpu_lds_n,
	input  logic                             strobe,
	input  logic                             to_mem,
	input  logic                             to_ram,
	output st_glue_pkg::bus_phase_t          bus_phase,
	output logic [st_glue_pkg::ADDR_W-1:0]   ram_addr,
	output logic                             ram_oe_n,
	output logic                             ram_we_n,
	output logic                             ram_uds_n,
	output logic                             ram_lds_n
);

	logic cpu_rd;	// strobed read of ram or rom
	logic cpu_wr;	// strobed write, ram only

	assign cpu_rd = strobe && cpu_rw && to_mem;
	assign cpu_wr = strobe && !cpu_rw && to_ram;	// rom/cart writes never reach ram

	// free running slot counter
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			bus_phase <= st_glue_pkg::PHASE_VIDEO;
		end else begin
			bus_phase <= st_glue_pkg::bus_phase_t'(bus_phase + 2'd1);	// wraps after spare
		end
	end

	always_comb begin
		// defaults: cpu bus on the port, no access
		ram_addr  = cpu_addr;
		ram_uds_n = cpu_uds_n;
		ram_lds_n = cpu_lds_n;
		ram_oe_n  = 1'b1;
		ram_we_n  = 1'b1;
		case (bus_phase)
			st_glue_pkg::PHASE_VIDEO: begin
				ram_addr  = video_addr;
				ram_uds_n = 1'b0;	// shifter reads whole words
				ram_lds_n = 1'b0;
				ram_oe_n  = !video_read;
			end
			st_glue_pkg::PHASE_CPU: begin
				ram_oe_n = !cpu_rd;
				ram_we_n = !cpu_wr;
			end
			default: begin
				ram_oe_n = 1'b1;	// host/spare slots idle here
			end
		endcase
	end

	// the ram must never see a read and a write in the same slot
	a_oe_we_excl: assert property (@(posedge clk_8) disable iff (!pll_locked)
		!(!ram_oe_n && !ram_we_n));

endmodule

/* rtl/st_glue_pkg.sv */
////////////////////////////////////////////////////////////
// shared widths, enums and constants for the ST bus glue
// window bases are byte offsets inside the $ffxxxx I/O page
////////////////////////////////////////////////////////////

package st_glue_pkg;

	// cpu bus widths
	localparam int ADDR_W = 23;	// word address, cpu A23..A1
	localparam int DATA_W = 16;

	// four-slot ram time slicing, one slot per clk_8
	typedef enum logic [1:0] {
		PHASE_VIDEO = 2'd0,	// shifter fetch
		PHASE_HOST  = 2'd1,	// host/io controller slot
		PHASE_CPU   = 2'd2,	// 68000 access
		PHASE_SPARE = 2'd3
	} bus_phase_t;

	// configured st ram size
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,	// extra 4 MB above $400000
		MEM_14M  = 3'd5	// extends up to $dfffff
	} mem_size_t;

	// vectors supplied for the st autovector levels
	localparam logic [7:0] VEC_VBI = 8'h1c;	// level 4
	localparam logic [7:0] VEC_HBI = 8'h1a;	// level 2

	// active low ipl codes, ipl[0] stays high on the st
	localparam logic [2:0] IPL_NONE = 3'b111;
	localparam logic [2:0] IPL_HBI  = 3'b101;
	localparam logic [2:0] IPL_VBI  = 3'b011;
	localparam logic [2:0] IPL_MFP  = 3'b001;

	// i/o window bases in the $ff page
	localparam logic [15:0] MMU_BASE  = 16'h8000;	// single word
	localparam logic [15:0] VREG_BASE = 16'h8200;	// 128 bytes
	localparam logic [15:0] DMA_BASE  = 16'h8600;	// 16 bytes
	localparam logic [15:0] PSG_BASE  = 16'h8800;	// 256 bytes
	localparam logic [15:0] MFP_BASE  = 16'hfa00;	// 256 bytes
	localparam logic [15:0] ACIA_BASE = 16'hfc00;	// 256 bytes

endpackage
